// ==== list.f ====
+incdir+common
common/dcd_reg_pkg.sv
common/dcd_cal_pkg.sv
rtl/apb_csr.sv
dcd_cal/dcd_sweep.sv
dcd_cal/dcd_get_sum.sv
rtl/apb_phy_master.sv
rtl/dcd_cal_top.sv
sim/phy_reg_model.sv
sim/dcd_cal_chk.sv
sim/tb_dcd_cal.sv

// ==== Makefile ====
TOP = tb_dcd_cal

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

# the run passes only if the pass message shows up in the output
sim:
	verilator --binary --assert -f list.f --top-module $(TOP) -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== sim/tb_dcd_cal.sv ====
`timescale 1ns/1ps
`include "dcd_config.svh"

module tb_dcd_cal;
    import dcd_reg_pkg::*;

    localparam int ACCESS_LIMIT = 16;
    localparam int STATUS_POLL_LIMIT = 5000;

    typedef struct {
        string name;
        int    first;
        int    last;
        bit    ack_on;
        int    exp_ofst;
        int    exp_sum_a;
        int    exp_sum_b;
        bit    exp_err;
    } test_row_t;

    logic clk;
    logic reset;
    logic [`CSR_ADDR_W-1:0] s_paddr;
    logic s_psel;
    logic s_penable;
    logic s_pwrite;
    logic [31:0] s_pwdata;
    logic [31:0] s_prdata;
    logic s_pready;
    logic s_pslverr;
    logic [`PHY_ADDR_W-1:0] m_paddr;
    logic m_psel;
    logic m_penable;
    logic m_pwrite;
    logic [`PHY_DATA_W-1:0] m_pwdata;
    logic [`PHY_DATA_W-1:0] m_prdata;
    logic m_pready;
    logic ack_enable;
    logic [`PHY_DATA_W-1:0] reye_mon;
    logic dcd_req;
    logic [31:0] xfer_count;

    test_row_t rows[$];
    int errors;
    int row_errors;
    bit hung;
    // name of the row being applied
    string cur_test;

    dcd_cal_top DUT (
        .clk       (clk),
        .reset     (reset),
        .s_paddr   (s_paddr),
        .s_psel    (s_psel),
        .s_penable (s_penable),
        .s_pwrite  (s_pwrite),
        .s_pwdata  (s_pwdata),
        .s_prdata  (s_prdata),
        .s_pready  (s_pready),
        .s_pslverr (s_pslverr),
        .m_paddr   (m_paddr),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwrite  (m_pwrite),
        .m_pwdata  (m_pwdata),
        .m_prdata  (m_prdata),
        .m_pready  (m_pready)
    );

    phy_reg_model u_phy (
        .clk        (clk),
        .reset      (reset),
        .paddr      (m_paddr),
        .psel       (m_psel),
        .penable    (m_penable),
        .pwrite     (m_pwrite),
        .pwdata     (m_pwdata),
        .prdata     (m_prdata),
        .pready     (m_pready),
        .ack_enable (ack_enable),
        .reye_mon   (reye_mon),
        .dcd_req    (dcd_req),
        .xfer_count (xfer_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input int exp, input int act);
        if (exp !== act)
        begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            errors++;
            row_errors++;
        end
    endtask

    // one transfer on the configuration port, driven on falling edges
    task automatic csr_access(input bit write, input logic [`CSR_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        rdata = '0;
        @(negedge clk);
        s_paddr = addr;
        s_pwrite = write;
        s_pwdata = wdata;
        s_psel = 1'b1;
        s_penable = 1'b0;
        @(negedge clk);
        s_penable = 1'b1;
        waits = 0;
        while (!s_pready && (waits < ACCESS_LIMIT))
        begin
            @(negedge clk);
            waits++;
        end
        if (!s_pready)
        begin
            $display("timeout: configuration port never raised pready");
            hung = 1'b1;
            errors++;
        end
        rdata = s_prdata;
        // the register block never signals a slave error
        check_value({cur_test, " pslverr"}, 0, int'(s_pslverr));
        @(negedge clk);
        s_psel = 1'b0;
        s_penable = 1'b0;
    endtask

    task automatic wait_sweep_done(output logic [31:0] status);
        int polls;
        polls = 0;
        csr_access(1'b0, CSR_STATUS, 32'd0, status);
        // done set and busy clear
        while (!hung && !(status[1] && !status[0]) && (polls < STATUS_POLL_LIMIT))
        begin
            csr_access(1'b0, CSR_STATUS, 32'd0, status);
            polls++;
        end
        if (!hung && !(status[1] && !status[0]))
        begin
            $display("timeout: sweep never reported done in the status register");
            hung = 1'b1;
            errors++;
        end
    endtask

    task automatic add_row(input string name, input int first, input int last,
                           input bit ack_on, input int ofst, input int sum_a,
                           input int sum_b, input bit err);
        test_row_t r;
        r.name = name;
        r.first = first;
        r.last = last;
        r.ack_on = ack_on;
        r.exp_ofst = ofst;
        r.exp_sum_a = sum_a;
        r.exp_sum_b = sum_b;
        r.exp_err = err;
        rows.push_back(r);
    endtask

    task automatic run_row(input test_row_t row, inout int applied_ofst);
        logic [31:0] data;
        int xfers_before;
        row_errors = 0;
        cur_test = row.name;
        ack_enable = row.ack_on;
        xfers_before = xfer_count;
        csr_access(1'b1, CSR_RANGE, 32'((row.last << 8) | row.first), data);
        csr_access(1'b1, CSR_CTRL, 32'd1, data);
        wait_sweep_done(data);
        if (!hung)
        begin
            check_value({row.name, " error"}, int'(row.exp_err), int'(data[2]));
            if (!row.exp_err)
            begin
                csr_access(1'b0, CSR_RESULT, 32'd0, data);
                check_value({row.name, " offset"}, row.exp_ofst, int'(data[5:0]));
                check_value({row.name, " sum_a"}, row.exp_sum_a, int'(data[15:8]));
                check_value({row.name, " sum_b"}, row.exp_sum_b, int'(data[23:16]));
            end
            // offset left in REYE_MON by this run
            if (row.first > row.last)
                check_value({row.name, " phy transfers"}, xfers_before, int'(xfer_count));
            else if (!row.ack_on)
            begin
                check_value({row.name, " request bit"}, 0, int'(dcd_req));
                applied_ofst = row.first;
            end
            else
                applied_ofst = row.last;
            check_value({row.name, " reye upper byte"}, 'hA5, int'(reye_mon[15:8]));
            check_value({row.name, " reye offset"}, applied_ofst, int'(reye_mon[5:0]));
            $display("%-16s %s", row.name, (row_errors == 0) ? "ok" : "mismatch");
        end
    endtask

    initial
    begin
        int applied_ofst;
        reset = 1'b1;
        s_paddr = '0;
        s_psel = 1'b0;
        s_penable = 1'b0;
        s_pwrite = 1'b0;
        s_pwdata = '0;
        ack_enable = 1'b1;
        errors = 0;
        row_errors = 0;
        hung = 1'b0;
        applied_ofst = 0;

        // name, first, last, ack, best offset, sum a, sum b, error
        add_row("full_range", 0, 63, 1'b1, 20, 160, 160, 1'b0);
        add_row("upper_range", 30, 40, 1'b1, 30, 190, 140, 1'b0);
        add_row("lower_range", 0, 10, 1'b1, 10, 130, 180, 1'b0);
        add_row("single_offset", 21, 21, 1'b1, 21, 163, 158, 1'b0);
        add_row("reversed_range", 9, 3, 1'b1, 0, 0, 0, 1'b1);
        add_row("no_ack", 5, 8, 1'b0, 0, 0, 0, 1'b1);

        repeat (3) @(negedge clk);
        reset = 1'b0;

        foreach (rows[i])
        begin
            if (!hung)
                run_row(rows[i], applied_ofst);
        end

        $display("tests %0d, mismatches %0d", rows.size(), errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== sim/dcd_cal_chk.sv ====
`timescale 1ns/1ps
`include "dcd_config.svh"

module dcd_cal_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   s_psel,
    input logic                   s_penable,
    input logic [`CSR_ADDR_W-1:0] s_paddr,
    input logic                   s_pready,
    input logic                   m_psel,
    input logic                   m_penable,
    input logic [`PHY_ADDR_W-1:0] m_paddr
);

    // access phase only right after a setup phase
    m_setup_first: assert property (@(posedge clk) disable iff (reset)
        $rose(m_penable) |-> $past(m_psel && !m_penable))
        else $error("phy port penable rose without a setup phase");

    s_setup_first: assert property (@(posedge clk) disable iff (reset)
        $rose(s_penable) |-> $past(s_psel && !s_penable))
        else $error("config port penable rose without a setup phase");

    m_addr_stable: assert property (@(posedge clk) disable iff (reset)
        m_psel && $past(m_psel) |-> $stable(m_paddr))
        else $error("phy port paddr changed while psel was high");

    s_addr_stable: assert property (@(posedge clk) disable iff (reset)
        s_psel && $past(s_psel) |-> $stable(s_paddr))
        else $error("config port paddr changed while psel was high");

    // config port has no wait states
    s_no_wait: assert property (@(posedge clk) disable iff (reset) s_pready)
        else $error("config port pready went low");

endmodule

bind dcd_cal_top dcd_cal_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .s_psel    (s_psel),
    .s_penable (s_penable),
    .s_paddr   (s_paddr),
    .s_pready  (s_pready),
    .m_psel    (m_psel),
    .m_penable (m_penable),
    .m_paddr   (m_paddr)
);

// ==== sim/phy_reg_model.sv ====
`timescale 1ns/1ps
`include "dcd_config.svh"

module phy_reg_model (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`PHY_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`PHY_DATA_W-1:0] pwdata,
    output logic [`PHY_DATA_W-1:0] prdata,
    output logic                   pready,
    input  logic                   ack_enable,
    output logic [`PHY_DATA_W-1:0] reye_mon,
    output logic                   dcd_req,
    output logic [31:0]            xfer_count
);
    import dcd_reg_pkg::*;

    integer seed = 32'ha370_cd7e;
    logic [1:0] wait_cnt;
    logic [7:0] poll_cnt;
    logic [`DCD_OFFSET_W-1:0] ofst;
    logic [`DCD_SUM_W-1:0] sum_a;
    logic [`DCD_SUM_W-1:0] sum_b;
    logic ack;
    logic xfer;

    // accumulators follow the offset field, wrapping at 8 bits
    assign ofst = reye_mon[REYE_OFST_LSB +: `DCD_OFFSET_W];
    assign sum_a = 8'(100 + 3 * ofst);
    assign sum_b = 8'(200 - 2 * ofst);

    // acknowledge shows up on the third poll after the request
    assign ack = dcd_req && ack_enable && (poll_cnt >= 8'd2);

    assign pready = (wait_cnt == 2'd0);
    assign xfer = psel && penable && pready;

    always_comb
    begin
        prdata = '0;
        if (paddr == REYE_MON_ADDR)
            prdata = reye_mon;
        else if (paddr == DCD_CTRL_ADDR)
        begin
            prdata[DCD_REQ_BIT] = dcd_req;
            prdata[DCD_ACK_BIT] = ack;
        end
        else if (paddr == DCD_RES_ADDR)
        begin
            prdata[SUM_A_LSB +: `DCD_SUM_W] = sum_a;
            prdata[SUM_B_LSB +: `DCD_SUM_W] = sum_b;
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            wait_cnt <= 2'd0;
            poll_cnt <= 8'd0;
            reye_mon <= 16'hA500;
            dcd_req <= 1'b0;
            xfer_count <= 32'd0;
        end
        else
        begin
            // wait cycles drawn in the setup phase
            if (psel && !penable)
                wait_cnt <= 2'($random(seed));
            else if (psel && penable && (wait_cnt != 2'd0))
                wait_cnt <= wait_cnt - 2'd1;
            if (xfer)
            begin
                xfer_count <= xfer_count + 32'd1;
                if (pwrite && (paddr == REYE_MON_ADDR))
                    reye_mon <= pwdata;
                else if (pwrite && (paddr == DCD_CTRL_ADDR))
                begin
                    dcd_req <= pwdata[DCD_REQ_BIT];
                    poll_cnt <= 8'd0;
                end
                else if (!pwrite && (paddr == DCD_CTRL_ADDR) && dcd_req)
                    poll_cnt <= poll_cnt + 8'd1;
            end
        end
    end

endmodule

// ==== rtl/dcd_cal_top.sv ====
`timescale 1ns/1ps
`include "dcd_config.svh"

module dcd_cal_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CSR_ADDR_W-1:0] s_paddr,
    input  logic                   s_psel,
    input  logic                   s_penable,
    input  logic                   s_pwrite,
    input  logic [31:0]            s_pwdata,
    output logic [31:0]            s_prdata,
    output logic                   s_pready,
    output logic                   s_pslverr,
    output logic [`PHY_ADDR_W-1:0] m_paddr,
    output logic                   m_psel,
    output logic                   m_penable,
    output logic                   m_pwrite,
    output logic [`PHY_DATA_W-1:0] m_pwdata,
    input  logic [`PHY_DATA_W-1:0] m_prdata,
    input  logic                   m_pready
);
    import dcd_cal_pkg::*;

    logic start;
    logic busy;
    logic sweep_done;
    logic error;
    logic [`DCD_OFFSET_W-1:0] first_ofst;
    logic [`DCD_OFFSET_W-1:0] last_ofst;
    logic [`DCD_OFFSET_W-1:0] best_ofst;
    logic [`DCD_SUM_W-1:0] best_sum_a;
    logic [`DCD_SUM_W-1:0] best_sum_b;

    // sweep to get-sum
    logic gs_go;
    logic gs_done;
    logic gs_timeout;
    logic [`DCD_OFFSET_W-1:0] gs_offset;
    logic [`DCD_SUM_W-1:0] gs_sum_a;
    logic [`DCD_SUM_W-1:0] gs_sum_b;

    // get-sum to apb master
    logic acc_req;
    logic acc_done;
    reg_op_e acc_op;
    logic [`PHY_ADDR_W-1:0] acc_addr;
    logic [`PHY_DATA_W-1:0] acc_wdata;
    logic [`PHY_DATA_W-1:0] acc_rdata;

    apb_csr u_csr (
        .clk        (clk),
        .reset      (reset),
        .paddr      (s_paddr),
        .psel       (s_psel),
        .penable    (s_penable),
        .pwrite     (s_pwrite),
        .pwdata     (s_pwdata),
        .prdata     (s_prdata),
        .pready     (s_pready),
        .pslverr    (s_pslverr),
        .start      (start),
        .first_ofst (first_ofst),
        .last_ofst  (last_ofst),
        .busy       (busy),
        .sweep_done (sweep_done),
        .error      (error),
        .best_ofst  (best_ofst),
        .best_sum_a (best_sum_a),
        .best_sum_b (best_sum_b)
    );

    dcd_sweep u_sweep (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .first_ofst (first_ofst),
        .last_ofst  (last_ofst),
        .busy       (busy),
        .done       (sweep_done),
        .error      (error),
        .best_ofst  (best_ofst),
        .best_sum_a (best_sum_a),
        .best_sum_b (best_sum_b),
        .gs_go      (gs_go),
        .gs_offset  (gs_offset),
        .gs_done    (gs_done),
        .gs_sum_a   (gs_sum_a),
        .gs_sum_b   (gs_sum_b),
        .gs_timeout (gs_timeout)
    );

    dcd_get_sum u_get_sum (
        .clk       (clk),
        .reset     (reset),
        .go        (gs_go),
        .offset    (gs_offset),
        .done      (gs_done),
        .sum_a     (gs_sum_a),
        .sum_b     (gs_sum_b),
        .timeout   (gs_timeout),
        .acc_req   (acc_req),
        .acc_op    (acc_op),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata),
        .acc_done  (acc_done),
        .acc_rdata (acc_rdata)
    );

    apb_phy_master u_phy_master (
        .clk     (clk),
        .reset   (reset),
        .req     (acc_req),
        .op      (acc_op),
        .addr    (acc_addr),
        .wdata   (acc_wdata),
        .done    (acc_done),
        .rdata   (acc_rdata),
        .paddr   (m_paddr),
        .psel    (m_psel),
        .penable (m_penable),
        .pwrite  (m_pwrite),
        .pwdata  (m_pwdata),
        .prdata  (m_prdata),
        .pready  (m_pready)
    );

endmodule

// ==== rtl/apb_phy_master.sv ====
`timescale 1ns/1ps
`include "dcd_config.svh"

module apb_phy_master (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  dcd_cal_pkg::reg_op_e   op,
    input  logic [`PHY_ADDR_W-1:0] addr,
    input  logic [`PHY_DATA_W-1:0] wdata,
    output logic                   done,
    output logic [`PHY_DATA_W-1:0] rdata,
    output logic [`PHY_ADDR_W-1:0] paddr,
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    output logic [`PHY_DATA_W-1:0] pwdata,
    input  logic [`PHY_DATA_W-1:0] prdata,
    input  logic                   pready
);
    import dcd_cal_pkg::*;

    logic xfer_end;

    assign xfer_end = psel && penable && pready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            psel <= 1'b0;
            penable <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= xfer_end;
            if (xfer_end)
            begin
                psel <= 1'b0;
                penable <= 1'b0;
            end
            else if (psel)
                penable <= 1'b1;
            else if (req)
                psel <= 1'b1;
        end
    end

    // bus fields held through the wait states
    always_ff @(posedge clk)
    begin
        if (req && !psel)
        begin
            paddr <= addr;
            pwrite <= (op == OP_WRITE);
            pwdata <= wdata;
        end
        if (xfer_end)
            rdata <= prdata;
    end

endmodule

// ==== dcd_cal/dcd_get_sum.sv ====
`timescale 1ns/1ps
`include "dcd_config.svh"

module dcd_get_sum (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     go,
    input  logic [`DCD_OFFSET_W-1:0] offset,
    output logic                     done,
    output logic [`DCD_SUM_W-1:0]    sum_a,
    output logic [`DCD_SUM_W-1:0]    sum_b,
    output logic                     timeout,
    output logic                     acc_req,
    output dcd_cal_pkg::reg_op_e     acc_op,
    output logic [`PHY_ADDR_W-1:0]   acc_addr,
    output logic [`PHY_DATA_W-1:0]   acc_wdata,
    input  logic                     acc_done,
    input  logic [`PHY_DATA_W-1:0]   acc_rdata
);
    import dcd_cal_pkg::*;
    import dcd_reg_pkg::*;

    localparam int POLL_CNT_W = $clog2(`DCD_ACK_POLL_MAX);
    localparam logic [POLL_CNT_W-1:0] POLL_LAST = POLL_CNT_W'(`DCD_ACK_POLL_MAX - 1);

    get_sum_state_e state;
    logic [POLL_CNT_W-1:0] poll_cnt;
    logic timed_out;
    // REYE_MON as read, for the read-modify-write
    logic [`PHY_DATA_W-1:0] reye_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= GS_IDLE;
            acc_req <= 1'b0;
            done <= 1'b0;
            timeout <= 1'b0;
            timed_out <= 1'b0;
            poll_cnt <= '0;
        end
        else
        begin
            acc_req <= 1'b0;
            done <= 1'b0;
            case (state)
                GS_IDLE:
                begin
                    if (go)
                    begin
                        timed_out <= 1'b0;
                        acc_req <= 1'b1;
                        state <= GS_RD_REYE;
                    end
                end
                GS_RD_REYE:
                begin
                    if (acc_done)
                    begin
                        acc_req <= 1'b1;
                        state <= GS_WR_REYE;
                    end
                end
                GS_WR_REYE:
                begin
                    if (acc_done)
                    begin
                        acc_req <= 1'b1;
                        state <= GS_REQ_ON;
                    end
                end
                GS_REQ_ON:
                begin
                    if (acc_done)
                    begin
                        poll_cnt <= '0;
                        acc_req <= 1'b1;
                        state <= GS_POLL;
                    end
                end
                GS_POLL:
                begin
                    if (acc_done)
                    begin
                        acc_req <= 1'b1;
                        if (acc_rdata[DCD_ACK_BIT])
                            state <= GS_REQ_OFF;
                        else if (poll_cnt == POLL_LAST)
                        begin
                            // give up, still drop the request
                            timed_out <= 1'b1;
                            state <= GS_REQ_OFF;
                        end
                        else
                            poll_cnt <= poll_cnt + 1'b1;
                    end
                end
                GS_REQ_OFF:
                begin
                    if (acc_done && timed_out)
                    begin
                        done <= 1'b1;
                        timeout <= 1'b1;
                        state <= GS_IDLE;
                    end
                    else if (acc_done)
                    begin
                        acc_req <= 1'b1;
                        state <= GS_RD_SUM;
                    end
                end
                GS_RD_SUM:
                begin
                    if (acc_done)
                    begin
                        done <= 1'b1;
                        timeout <= 1'b0;
                        state <= GS_IDLE;
                    end
                end
                default:
                begin
                    state <= GS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == GS_RD_REYE) && acc_done)
            reye_q <= acc_rdata;
        if ((state == GS_RD_SUM) && acc_done)
        begin
            sum_a <= acc_rdata[SUM_A_LSB +: `DCD_SUM_W];
            sum_b <= acc_rdata[SUM_B_LSB +: `DCD_SUM_W];
        end
    end

    // access fields follow the state, so they hold from req until done
    always_comb
    begin
        acc_op = OP_READ;
        acc_addr = DCD_CTRL_ADDR;
        acc_wdata = '0;
        case (state)
            GS_RD_REYE:
            begin
                acc_addr = REYE_MON_ADDR;
            end
            GS_WR_REYE:
            begin
                acc_op = OP_WRITE;
                acc_addr = REYE_MON_ADDR;
                acc_wdata = reye_q;
                acc_wdata[REYE_OFST_LSB +: `DCD_OFFSET_W] = offset;
            end
            GS_REQ_ON:
            begin
                acc_op = OP_WRITE;
                acc_wdata[DCD_REQ_BIT] = 1'b1;
            end
            GS_REQ_OFF:
            begin
                acc_op = OP_WRITE;
            end
            GS_RD_SUM:
            begin
                acc_addr = DCD_RES_ADDR;
            end
            default:
            begin
                acc_op = OP_READ;
            end
        endcase
    end

endmodule

// ==== dcd_cal/dcd_sweep.sv ====
`timescale 1ns/1ps
`include "dcd_config.svh"

module dcd_sweep (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic [`DCD_OFFSET_W-1:0] first_ofst,
    input  logic [`DCD_OFFSET_W-1:0] last_ofst,
    output logic                     busy,
    output logic                     done,
    output logic                     error,
    output logic [`DCD_OFFSET_W-1:0] best_ofst,
    output logic [`DCD_SUM_W-1:0]    best_sum_a,
    output logic [`DCD_SUM_W-1:0]    best_sum_b,
    output logic                     gs_go,
    output logic [`DCD_OFFSET_W-1:0] gs_offset,
    input  logic                     gs_done,
    input  logic [`DCD_SUM_W-1:0]    gs_sum_a,
    input  logic [`DCD_SUM_W-1:0]    gs_sum_b,
    input  logic                     gs_timeout
);
    import dcd_cal_pkg::*;

    sweep_state_e state;

    // one extra bit so the first offset always beats the initial value
    logic [`DCD_SUM_W:0] best_diff;
    logic [`DCD_SUM_W:0] diff;

    always_comb
    begin
        if (gs_sum_a > gs_sum_b)
            diff = {1'b0, gs_sum_a - gs_sum_b};
        else
            diff = {1'b0, gs_sum_b - gs_sum_a};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= SW_IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            error <= 1'b0;
            gs_go <= 1'b0;
            gs_offset <= '0;
        end
        else
        begin
            done <= 1'b0;
            gs_go <= 1'b0;
            case (state)
                SW_IDLE:
                begin
                    if (start && (first_ofst > last_ofst))
                    begin
                        // empty range, finish without touching the phy
                        done <= 1'b1;
                        error <= 1'b1;
                    end
                    else if (start)
                    begin
                        busy <= 1'b1;
                        error <= 1'b0;
                        gs_offset <= first_ofst;
                        state <= SW_RUN;
                    end
                end
                SW_RUN:
                begin
                    gs_go <= 1'b1;
                    state <= SW_WAIT;
                end
                SW_WAIT:
                begin
                    if (gs_done && gs_timeout)
                    begin
                        error <= 1'b1;
                        state <= SW_FINISH;
                    end
                    else if (gs_done && (gs_offset == last_ofst))
                    begin
                        state <= SW_FINISH;
                    end
                    else if (gs_done)
                    begin
                        gs_offset <= gs_offset + 1'b1;
                        state <= SW_RUN;
                    end
                end
                SW_FINISH:
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    state <= SW_IDLE;
                end
                default:
                begin
                    state <= SW_IDLE;
                end
            endcase
        end
    end

    // best offset tracking, strict minimum keeps the earlier offset on a tie
    always_ff @(posedge clk)
    begin
        if ((state == SW_IDLE) && start)
            best_diff <= {1'b1, {`DCD_SUM_W{1'b0}}};
        else if ((state == SW_WAIT) && gs_done && !gs_timeout && (diff < best_diff))
        begin
            best_diff <= diff;
            best_ofst <= gs_offset;
            best_sum_a <= gs_sum_a;
            best_sum_b <= gs_sum_b;
        end
    end

endmodule

// ==== rtl/apb_csr.sv ====
`timescale 1ns/1ps
`include "dcd_config.svh"

module apb_csr (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`CSR_ADDR_W-1:0]   paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     start,
    output logic [`DCD_OFFSET_W-1:0] first_ofst,
    output logic [`DCD_OFFSET_W-1:0] last_ofst,
    input  logic                     busy,
    input  logic                     sweep_done,
    input  logic                     error,
    input  logic [`DCD_OFFSET_W-1:0] best_ofst,
    input  logic [`DCD_SUM_W-1:0]    best_sum_a,
    input  logic [`DCD_SUM_W-1:0]    best_sum_b
);
    import dcd_reg_pkg::*;

    logic wr_en;
    logic done_q;
    logic error_q;

    // no wait states, no slave errors
    assign pready = 1'b1;
    assign pslverr = 1'b0;

    assign wr_en = psel && penable && pwrite;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start <= 1'b0;
            first_ofst <= '0;
            last_ofst <= '0;
            done_q <= 1'b0;
            error_q <= 1'b0;
        end
        else
        begin
            start <= wr_en && (paddr == CSR_CTRL) && pwdata[0] && !busy;
            if (wr_en && (paddr == CSR_RANGE))
            begin
                first_ofst <= pwdata[0 +: `DCD_OFFSET_W];
                last_ofst <= pwdata[8 +: `DCD_OFFSET_W];
            end
            // sticky until the next accepted start
            if (start)
            begin
                done_q <= 1'b0;
                error_q <= 1'b0;
            end
            else if (sweep_done)
            begin
                done_q <= 1'b1;
                error_q <= error;
            end
        end
    end

    always_comb
    begin
        prdata = '0;
        case (paddr)
            CSR_STATUS:
            begin
                prdata[0] = busy;
                prdata[1] = done_q;
                prdata[2] = error_q;
            end
            CSR_RANGE:
            begin
                prdata[0 +: `DCD_OFFSET_W] = first_ofst;
                prdata[8 +: `DCD_OFFSET_W] = last_ofst;
            end
            CSR_RESULT:
            begin
                prdata[0 +: `DCD_OFFSET_W] = best_ofst;
                prdata[8 +: `DCD_SUM_W] = best_sum_a;
                prdata[16 +: `DCD_SUM_W] = best_sum_b;
            end
            default:
            begin
                prdata = '0;
            end
        endcase
    end

endmodule

// ==== common/dcd_cal_pkg.sv ====
package dcd_cal_pkg;

    // single register access toward the phy
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } reg_op_e;

    // per-offset get-sum sequence
    typedef enum logic [2:0] {
        GS_IDLE,
        GS_RD_REYE,
        GS_WR_REYE,
        GS_REQ_ON,
        GS_POLL,
        GS_REQ_OFF,
        GS_RD_SUM
    } get_sum_state_e;

    // offset sweep
    typedef enum logic [1:0] {
        SW_IDLE,
        SW_RUN,
        SW_WAIT,
        SW_FINISH
    } sweep_state_e;

endpackage

// ==== common/dcd_reg_pkg.sv ====
`include "dcd_config.svh"

package dcd_reg_pkg;

    // phy register addresses
    localparam logic [`PHY_ADDR_W-1:0] REYE_MON_ADDR = 12'h120;
    localparam logic [`PHY_ADDR_W-1:0] DCD_CTRL_ADDR = 12'h140;
    localparam logic [`PHY_ADDR_W-1:0] DCD_RES_ADDR = 12'h141;

    // offset field of REYE_MON
    localparam int REYE_OFST_LSB = 0;

    // dcd control register, request is written and acknowledge is read
    localparam int DCD_REQ_BIT = 0;
    localparam int DCD_ACK_BIT = 1;

    // accumulator fields of the result register
    localparam int SUM_A_LSB = 0;
    localparam int SUM_B_LSB = 8;

    // configuration register offsets
    localparam logic [`CSR_ADDR_W-1:0] CSR_CTRL = 4'h0;
    localparam logic [`CSR_ADDR_W-1:0] CSR_STATUS = 4'h4;
    localparam logic [`CSR_ADDR_W-1:0] CSR_RANGE = 4'h8;
    localparam logic [`CSR_ADDR_W-1:0] CSR_RESULT = 4'hC;

endpackage

// ==== common/dcd_config.svh ====
`ifndef DCD_CONFIG_SVH
`define DCD_CONFIG_SVH

// dcd offset and accumulator widths
`define DCD_OFFSET_W 6
`define DCD_SUM_W 8

// phy register space
`define PHY_ADDR_W 12
`define PHY_DATA_W 16

// configuration port address width
`define CSR_ADDR_W 4

// acknowledge polls before a get-sum run gives up
`define DCD_ACK_POLL_MAX 16

`endif
